// File: Makefile
# Verilator build and run for the reduced RV64 integer pipeline

SRCS := $(wildcard src/*.sv src/*.svh verification/*.sv)

.PHONY: all run clean

all: obj_dir/Vint_pipe_tb

obj_dir/Vint_pipe_tb: $(SRCS) verilog.f
	verilator --binary -f verilog.f --top-module int_pipe_tb -Mdir obj_dir

run: obj_dir/Vint_pipe_tb
	./obj_dir/Vint_pipe_tb | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: src/alu_execute.sv
/* execute stage that picks forwarded operands, runs the 64-bit ALU
   and registers the result for the result stage */
`timescale 1ns/1ps

`include "core_defines.svh"

module alu_execute
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  logic         dec_valid,
  input  decoded_t     dec,
  input  logic         commit_valid,
  input  commit_t      commit,
  output logic         res_valid,
  output exec_result_t res
);

  localparam int SHAMT_W = $clog2(`XLEN);

  word_t              op_a;
  word_t              op_b;
  word_t              alu_out;
  logic [SHAMT_W-1:0] shamt;

  // nearest producer wins over older ones and over the file
  function automatic word_t forward_operand(input reg_addr_t addr, input word_t file_data);
    word_t value;
    if (res_valid && res.wr_ena && (res.rd == addr)) begin
      value = res.data;
    end else if (commit_valid && commit.wr_ena && (commit.rd == addr)) begin
      value = commit.data;
    end else begin
      value = file_data;
    end
    return value;
  endfunction

  always_comb begin
    op_a = dec.use_rs1 ? forward_operand(dec.rs1, dec.rs1_data) : '0;
    op_b = dec.use_rs2 ? forward_operand(dec.rs2, dec.rs2_data) : dec.imm;
  end

  assign shamt = op_b[SHAMT_W-1:0];

  always_comb begin
    case (dec.alu_op)
      ALU_ADD:    alu_out = op_a + op_b;
      ALU_SUB:    alu_out = op_a - op_b;
      ALU_AND:    alu_out = op_a & op_b;
      ALU_OR:     alu_out = op_a | op_b;
      ALU_XOR:    alu_out = op_a ^ op_b;
      ALU_SLL:    alu_out = op_a << shamt;
      ALU_SRL:    alu_out = op_a >> shamt;
      ALU_SRA:    alu_out = word_t'($signed(op_a) >>> shamt);
      ALU_SLT:    alu_out = word_t'($signed(op_a) < $signed(op_b));
      ALU_SLTU:   alu_out = word_t'(op_a < op_b);
      ALU_PASS_B: alu_out = op_b;
      default:    alu_out = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= dec_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (dec_valid) begin
      res.rd     <= dec.rd;
      res.wr_ena <= dec.wr_ena;
      res.data   <= alu_out;
    end
  end

endmodule

// File: src/core_defines.svh
/* core constants for the reduced RV64 integer pipeline
   widths, register count and the opcode and funct encodings */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// data and register widths
`define XLEN        64
`define REG_ADDR_W  5
`define REG_COUNT   32

// major opcodes, inst[6:0]
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111

// funct3 codes
`define F3_ADD      3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// bit inside funct7 that picks sub or sra
`define F7_ALT      5

`endif

// File: src/inst_decode.sv
/* decode stage that splits the instruction, builds the immediate and ALU op,
   reads the register file and registers the decoded record */
`timescale 1ns/1ps

`include "core_defines.svh"

module inst_decode
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  logic      inst_valid,
  input  inst_t     inst,
  output reg_addr_t rs1_addr,
  output reg_addr_t rs2_addr,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  output logic      dec_valid,
  output decoded_t  dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rd_field;
  logic       alt;
  word_t      imm_i;
  word_t      imm_u;
  decoded_t   dec_next;

  function automatic alu_op_e map_alu_op(input logic [2:0] f3, input logic alt_bit,
                                         input logic reg_form);
    alu_op_e op;
    case (f3)
      `F3_ADD:  op = (alt_bit && reg_form) ? ALU_SUB : ALU_ADD;
      `F3_SLL:  op = ALU_SLL;
      `F3_SLT:  op = ALU_SLT;
      `F3_SLTU: op = ALU_SLTU;
      `F3_XOR:  op = ALU_XOR;
      `F3_SR:   op = alt_bit ? ALU_SRA : ALU_SRL;
      `F3_OR:   op = ALU_OR;
      `F3_AND:  op = ALU_AND;
      default:  op = ALU_ADD;
    endcase
    return op;
  endfunction

  assign opcode   = inst[6:0];
  assign rd_field = inst[11:7];
  assign funct3   = inst[14:12];
  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];
  assign funct7   = inst[31:25];
  assign alt      = funct7[`F7_ALT];

  assign imm_i     = word_t'($signed(inst[31:20]));
  assign imm_u     = word_t'($signed({inst[31:12], 12'b0}));

  always_comb begin
    dec_next          = '0;
    dec_next.alu_op   = ALU_ADD;
    dec_next.rs1      = rs1_addr;
    dec_next.rs2      = rs2_addr;
    dec_next.rs1_data = rs1_data;
    dec_next.rs2_data = rs2_data;
    dec_next.rd       = rd_field;
    dec_next.imm      = imm_i;
    case (opcode)
      `OPC_OP: begin
        dec_next.use_rs1 = 1'b1;
        dec_next.use_rs2 = 1'b1;
        dec_next.wr_ena  = 1'b1;
        dec_next.alu_op  = map_alu_op(funct3, alt, 1'b1);
      end
      // rv64 shift immediates keep their 6-bit shamt in imm[5:0]
      `OPC_OP_IMM: begin
        dec_next.use_rs1 = 1'b1;
        dec_next.wr_ena  = 1'b1;
        dec_next.alu_op  = map_alu_op(funct3, alt, 1'b0);
      end
      `OPC_LUI: begin
        dec_next.wr_ena = 1'b1;
        dec_next.imm    = imm_u;
        dec_next.alu_op = ALU_PASS_B;
      end
      // anything else retires without a write
      default: begin
      end
    endcase
    if (rd_field == '0) begin
      dec_next.wr_ena = 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= inst_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (inst_valid) begin
      dec <= dec_next;
    end
  end

endmodule

// File: src/int_pipe_top.sv
/* reduced RV64 integer pipeline: decode, execute and result stages,
   one commit strobe per instruction three cycles after issue */
`timescale 1ns/1ps

module int_pipe_top
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  logic    inst_valid,
  input  inst_t   inst,
  output logic    commit_valid,
  output commit_t commit
);

  reg_addr_t    rs1_addr;
  reg_addr_t    rs2_addr;
  word_t        rs1_data;
  word_t        rs2_data;
  logic         dec_valid;
  decoded_t     dec;
  logic         res_valid;
  exec_result_t res;

  inst_decode i_inst_decode (
    .clock(clock), .reset(reset), .inst_valid(inst_valid), .inst(inst),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .dec_valid(dec_valid), .dec(dec)
  );

  alu_execute i_alu_execute (
    .clock(clock), .reset(reset), .dec_valid(dec_valid), .dec(dec),
    .commit_valid(commit_valid), .commit(commit), .res_valid(res_valid), .res(res)
  );

  reg_writeback i_reg_writeback (
    .clock(clock), .reset(reset), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .res_valid(res_valid), .res(res),
    .commit_valid(commit_valid), .commit(commit)
  );

endmodule

// File: src/isa_pkg.sv
/* ISA level types for the integer pipeline
   data words, instruction words, register indices and ALU operations */
`include "core_defines.svh"

package isa_pkg;

  typedef logic [`XLEN-1:0]       word_t;
  typedef logic [31:0]            inst_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

  // pass_b carries the LUI immediate straight through
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_PASS_B
  } alu_op_e;

endpackage

// File: src/pipe_pkg.sv
/* records passed between the decode, execute and result stages */
package pipe_pkg;

  import isa_pkg::*;

  // decode -> execute
  typedef struct packed {
    alu_op_e   alu_op;
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic      use_rs1;
    logic      use_rs2;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     imm;
    reg_addr_t rd;
    logic      wr_ena;
  } decoded_t;

  // execute -> result stage
  typedef struct packed {
    reg_addr_t rd;
    logic      wr_ena;
    word_t     data;
  } exec_result_t;

  // retired instruction, seen outside the core
  typedef struct packed {
    reg_addr_t rd;
    logic      wr_ena;
    word_t     data;
  } commit_t;

endpackage

// File: src/reg_writeback.sv
/* result stage: integer register file with two read ports,
   written by retiring instructions, plus the commit register */
`timescale 1ns/1ps

`include "core_defines.svh"

module reg_writeback
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  reg_addr_t    rs1_addr,
  input  reg_addr_t    rs2_addr,
  output word_t        rs1_data,
  output word_t        rs2_data,
  input  logic         res_valid,
  input  exec_result_t res,
  output logic         commit_valid,
  output commit_t      commit
);

  word_t regs [`REG_COUNT];

  // x0 is hardwired
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (res_valid && res.wr_ena && (res.rd != '0)) begin
      regs[res.rd] <= res.data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      commit_valid <= 1'b0;
    end else begin
      commit_valid <= res_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (res_valid) begin
      commit.rd     <= res.rd;
      commit.wr_ena <= res.wr_ena;
      commit.data   <= res.data;
    end
  end

endmodule

// File: verification/int_pipe_patterns.txt
# columns: test name, instruction word (hex), expected wr_ena, rd (decimal), data (hex)
# names ending in _b2b are issued right after the previous instruction
reset_add        002081B3 1 3  0000000000000000
addi_pos         00500093 1 1  0000000000000005
addi_neg         FFF00113 1 2  FFFFFFFFFFFFFFFF
ori_pos          7F006213 1 4  00000000000007F0
xori_neg         80004293 1 5  FFFFFFFFFFFFF800
andi_neg         FFF07313 1 6  0000000000000000
slti_neg         FFF02393 1 7  0000000000000000
sltiu_neg        FFF03413 1 8  0000000000000001
lui_neg          800004B7 1 9  FFFFFFFF80000000
lui_pos          12345537 1 10 0000000012345000
chain1_b2b       00700593 1 11 0000000000000007
chain2_b2b       00B58633 1 12 000000000000000E
chain3_b2b       40B606B3 1 13 0000000000000007
chain4_b2b       00C6C733 1 14 0000000000000009
chain5_b2b       00D705B3 1 11 0000000000000010
chain6_b2b       00B587B3 1 15 0000000000000020
chain1_gap       00700593 1 11 0000000000000007
chain2_gap       00B58633 1 12 000000000000000E
chain3_gap       40B606B3 1 13 0000000000000007
chain4_gap       00C6C733 1 14 0000000000000009
chain5_gap       00D705B3 1 11 0000000000000010
chain6_gap       00B587B3 1 15 0000000000000020
lui_setup        F0F0F837 1 16 FFFFFFFFF0F0F000
addi_setup       12300893 1 17 0000000000000123
add_reg          01180933 1 18 FFFFFFFFF0F0F123
sub_reg          410889B3 1 19 000000000F0F1123
and_reg          00A87A33 1 20 0000000010305000
or_reg           00A86AB3 1 21 FFFFFFFFF2F4F000
xor_reg          00A84B33 1 22 FFFFFFFFE2C4A000
sll_reg_35       01181BB3 1 23 8787800000000000
srl_reg_35       01185C33 1 24 000000001FFFFFFF
sra_reg_35       41185CB3 1 25 FFFFFFFFFFFFFFFF
srai_40          428BDD13 1 26 FFFFFFFFFF878780
slli_50          03289D93 1 27 048C000000000000
srli_36          02485E13 1 28 000000000FFFFFFF
slt_signed       00A82EB3 1 29 0000000000000001
sltu_signed      00A83F33 1 30 0000000000000000
x0_write         00900013 0 0  0000000000000000
x0_read_b2b      00000FB3 1 31 0000000000000000
unsup_op         0FF0008B 0 1  0000000000000000
unsup_read_b2b   00008F93 1 31 0000000000000005
x0_read_late     00000FB3 1 31 0000000000000000

// File: verification/int_pipe_tb.sv
/* testbench for the integer pipeline: issues instruction words from the
   pattern file with random gaps and checks every commit in order */
`timescale 1ns/1ps

module int_pipe_tb
  import isa_pkg::*;
  import pipe_pkg::*;
();

  localparam string PATTERN_FILE = "verification/int_pipe_patterns.txt";
  localparam int COMMIT_TIMEOUT = 20;

  logic    clock;
  logic    reset;
  logic    inst_valid;
  inst_t   inst;
  logic    commit_valid;
  commit_t commit;

  string     names[$];
  inst_t     inst_q[$];
  logic      exp_wr_q[$];
  reg_addr_t exp_rd_q[$];
  word_t     exp_data_q[$];

  int pass_count;
  int fail_count;
  bit test_ok;
  bit load_ok;

  int_pipe_top i_int_pipe_top (
    .clock(clock), .reset(reset), .inst_valid(inst_valid), .inst(inst),
    .commit_valid(commit_valid), .commit(commit)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  function automatic bit is_back_to_back(input string name);
    int len;
    len = name.len();
    return (len >= 4) && (name.substr(len - 4, len - 1) == "_b2b");
  endfunction

  task automatic load_patterns(output bit ok);
    int          fd;
    int          code;
    int          wr_val;
    int          rd_val;
    bit          done;
    string       token;
    string       rest;
    logic [31:0] inst_val;
    logic [63:0] data_val;
    ok = 1'b0;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd != 0) begin
      ok = 1'b1;
      done = 1'b0;
      while (!done) begin
        code = $fscanf(fd, "%s", token);
        if (code != 1) begin
          done = 1'b1;
        end else if (token.substr(0, 0) == "#") begin
          code = $fgets(rest, fd);
        end else begin
          code = $fscanf(fd, "%h %d %d %h", inst_val, wr_val, rd_val, data_val);
          if (code != 4) begin
            ok = 1'b0;
            done = 1'b1;
          end else begin
            names.push_back(token);
            inst_q.push_back(inst_val);
            exp_wr_q.push_back(wr_val != 0);
            exp_rd_q.push_back(reg_addr_t'(rd_val));
            exp_data_q.push_back(data_val);
          end
        end
      end
      $fclose(fd);
    end
    if (names.size() == 0) begin
      ok = 1'b0;
    end
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("mismatch %s data: expected %h actual %h", name, expected, actual);
      test_ok = 1'b0;
    end
  endtask

  task automatic check_addr(input string name, input reg_addr_t expected,
                            input reg_addr_t actual);
    if (actual !== expected) begin
      $display("mismatch %s rd: expected %0d actual %0d", name, expected, actual);
      test_ok = 1'b0;
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("mismatch %s wr_ena: expected %b actual %b", name, expected, actual);
      test_ok = 1'b0;
    end
  endtask

  // gap cycles drop the strobe, _b2b names follow with none
  task automatic drive_all();
    int gap;
    for (int i = 0; i < names.size(); i++) begin
      gap = is_back_to_back(names[i]) ? 0 : int'($urandom % 4);
      repeat (gap) begin
        @(posedge clock);
        inst_valid <= 1'b0;
      end
      @(posedge clock);
      inst_valid <= 1'b1;
      inst       <= inst_q[i];
    end
    @(posedge clock);
    inst_valid <= 1'b0;
  endtask

  // sampled on the falling edge, away from the register updates
  task automatic wait_commit(output bit got);
    int waited;
    got = 1'b0;
    waited = 0;
    while (!got && waited < COMMIT_TIMEOUT) begin
      @(negedge clock);
      if (commit_valid) begin
        got = 1'b1;
      end else begin
        waited++;
      end
    end
  endtask

  task automatic check_all();
    bit got;
    for (int i = 0; i < names.size(); i++) begin
      wait_commit(got);
      if (!got) begin
        $display("test %s: no commit arrived within %0d cycles", names[i], COMMIT_TIMEOUT);
        fail_count++;
        break;
      end
      test_ok = 1'b1;
      check_bit(names[i], exp_wr_q[i], commit.wr_ena);
      check_addr(names[i], exp_rd_q[i], commit.rd);
      // data of a commit without a write is not defined
      if (exp_wr_q[i]) begin
        check_word(names[i], exp_data_q[i], commit.data);
      end
      if (test_ok) begin
        pass_count++;
        $display("test %s pass", names[i]);
      end else begin
        fail_count++;
        $display("test %s fail", names[i]);
      end
    end
  endtask

  initial begin
    void'($urandom(32'h0f2243bc));
    reset      <= 1'b1;
    inst_valid <= 1'b0;
    inst       <= '0;
    pass_count = 0;
    fail_count = 0;
    load_patterns(load_ok);
    if (!load_ok) begin
      $display("could not read test patterns from %s", PATTERN_FILE);
      $display("TESTS FAILED");
      $finish;
    end else begin
      repeat (8) @(posedge clock);
      reset <= 1'b0;
      fork
        drive_all();
        check_all();
      join
      $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
      if (fail_count == 0 && pass_count == names.size()) begin
        $display("TESTS PASSED");
      end else begin
        $display("TESTS FAILED");
      end
      $finish;
    end
  end

endmodule

// File: verilog.f
+incdir+src
src/isa_pkg.sv
src/pipe_pkg.sv
src/inst_decode.sv
src/alu_execute.sv
src/reg_writeback.sv
src/int_pipe_top.sv
verification/int_pipe_tb.sv
